/* filelist.f */
+incdir+sim
hw/cam_pkg.sv
hw/cam_cmd_if.sv
hw/cam_match_if.sv
hw/cam_ingress.sv
hw/clause_bank.sv
hw/match_collector.sv
hw/cam_core.sv
sim/tb_cam_core.sv

/* hw/cam_cmd_if.sv */
`timescale 1ns/1ns
`default_nettype none

// stage-1 command broadcast, one source and many banks
interface cam_cmd_if #(
  parameter int NUM_CLAUSES = 16
);

  // strobes, only meaningful when advance is high
  logic                             cmd_write;
  logic                             cmd_infer;

  // operands of the registered command
  logic [$clog2(NUM_CLAUSES)-1:0]   cmd_clause;
  logic                             cmd_tkind;
  cam_pkg::vars_t                   cmd_vars;
  cam_pkg::leaf_t                   cmd_leaf;
  cam_pkg::tree_id_t                cmd_tree_id;
  cam_pkg::class_id_t               cmd_class_id;

  // sticky per-variable don't-care mask
  logic [cam_pkg::NUM_VARS-1:0]     dont_care;

  // whole pipeline moves on this, driven from the output side
  logic                             advance;

  modport ingress (
    output cmd_write, cmd_infer, cmd_clause, cmd_tkind, cmd_vars,
    output cmd_leaf, cmd_tree_id, cmd_class_id, dont_care,
    input  advance
  );

  modport bank (
    input cmd_write, cmd_infer, cmd_clause, cmd_tkind, cmd_vars,
    input cmd_leaf, cmd_tree_id, cmd_class_id, dont_care,
    input advance
  );

  modport collector (
    input  cmd_infer,
    output advance
  );

endinterface

`default_nettype wire

/* hw/cam_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_core #(
  parameter  int NUM_CLAUSES       = 16,
  parameter  int NUM_BANKS         = 4,
  parameter  int BRANCHES_PER_SLOT = 2,
  localparam int NUM_SLOTS         = NUM_CLAUSES / BRANCHES_PER_SLOT
) (
  input  logic                                    clk,
  input  logic                                    rst_3,

  // command input
  input  cam_pkg::mode_t                          i_mode,
  input  logic [$clog2(NUM_CLAUSES)-1:0]          i_clause,
  input  logic [$clog2(cam_pkg::NUM_VARS)-1:0]    i_variable,
  input  logic                                    i_threshold_kind,
  input  cam_pkg::vars_t                          i_vars,
  input  cam_pkg::leaf_t                          i_leaf,
  input  cam_pkg::tree_id_t                       i_tree_id,
  input  cam_pkg::class_id_t                      i_class_id,
  output logic                                    o_ready,

  // result stream
  input  logic                                    i_out_ready,
  output logic                                    o_valid,
  output cam_pkg::leaf_t     [NUM_SLOTS-1:0]      o_leaves,
  output cam_pkg::tree_id_t  [NUM_SLOTS-1:0]      o_tree_ids,
  output cam_pkg::class_id_t [NUM_SLOTS-1:0]      o_class_ids
);

  localparam int CLAUSES_PER_BANK = NUM_CLAUSES / NUM_BANKS;

  cam_cmd_if #(.NUM_CLAUSES(NUM_CLAUSES)) cmd_bus ();

  cam_match_if #(.CLAUSES_PER_BANK(CLAUSES_PER_BANK)) match_bus [NUM_BANKS] ();

  assign o_ready = cmd_bus.advance;

  cam_ingress #(
    .NUM_CLAUSES      (NUM_CLAUSES)
  ) u_ingress (
    .clk              (clk),
    .rst_3            (rst_3),
    .i_mode           (i_mode),
    .i_clause         (i_clause),
    .i_variable       (i_variable),
    .i_threshold_kind (i_threshold_kind),
    .i_vars           (i_vars),
    .i_leaf           (i_leaf),
    .i_tree_id        (i_tree_id),
    .i_class_id       (i_class_id),
    .cmd              (cmd_bus.ingress)
  );

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    clause_bank #(
      .CLAUSES_PER_BANK (CLAUSES_PER_BANK),
      .BANK_INDEX       (b),
      .NUM_CLAUSES      (NUM_CLAUSES)
    ) u_bank (
      .clk              (clk),
      .rst_3            (rst_3),
      .cmd              (cmd_bus.bank),
      .match            (match_bus[b].bank)
    );
  end

  match_collector #(
    .NUM_CLAUSES       (NUM_CLAUSES),
    .NUM_BANKS         (NUM_BANKS),
    .BRANCHES_PER_SLOT (BRANCHES_PER_SLOT)
  ) u_collector (
    .clk               (clk),
    .rst_3             (rst_3),
    .cmd               (cmd_bus.collector),
    .banks             (match_bus),
    .i_out_ready       (i_out_ready),
    .o_valid           (o_valid),
    .o_leaves          (o_leaves),
    .o_tree_ids        (o_tree_ids),
    .o_class_ids       (o_class_ids)
  );

endmodule

`default_nettype wire

/* hw/cam_ingress.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_ingress #(
  parameter int NUM_CLAUSES = 16
) (
  input  logic                                  clk,
  input  logic                                  rst_3,

  input  cam_pkg::mode_t                        i_mode,
  input  logic [$clog2(NUM_CLAUSES)-1:0]        i_clause,
  input  logic [$clog2(cam_pkg::NUM_VARS)-1:0]  i_variable,
  input  logic                                  i_threshold_kind,
  input  cam_pkg::vars_t                        i_vars,
  input  cam_pkg::leaf_t                        i_leaf,
  input  cam_pkg::tree_id_t                     i_tree_id,
  input  cam_pkg::class_id_t                    i_class_id,

  cam_cmd_if.ingress                            cmd
);

  logic accept;

  // a command is taken whenever the pipeline moves and mode is not idle
  assign accept = cmd.advance && (i_mode != cam_pkg::MODE_IDLE);

  //////////////////////////////////////////////////
  // stage 1 strobes and mask
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst_3)
    begin
      cmd.cmd_write <= 1'b0;
      cmd.cmd_infer <= 1'b0;
      cmd.dont_care <= '0;
    end
    else
    begin
      // idle mode loads zero strobes, so a bubble enters stage 1
      if (cmd.advance)
      begin
        cmd.cmd_write <= (i_mode == cam_pkg::MODE_WRITE);
        cmd.cmd_infer <= (i_mode == cam_pkg::MODE_INFER);
      end

      // once set a variable stays don't-care until reset
      if (accept && (i_mode == cam_pkg::MODE_DONT_CARE))
      begin
        cmd.dont_care[i_variable] <= 1'b1;
      end
    end
  end

  // operands follow the strobes
  always_ff @(posedge clk)
  begin
    if (cmd.advance)
    begin
      cmd.cmd_clause   <= i_clause;
      cmd.cmd_tkind    <= i_threshold_kind;
      cmd.cmd_vars     <= i_vars;
      cmd.cmd_leaf     <= i_leaf;
      cmd.cmd_tree_id  <= i_tree_id;
      cmd.cmd_class_id <= i_class_id;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // one command per stage, a write and a query never share it
  a_one_strobe: assert property (
    @(posedge clk) disable iff (rst_3)
    !(cmd.cmd_write && cmd.cmd_infer)
  );

endmodule

`default_nettype wire

/* hw/cam_match_if.sv */
`timescale 1ns/1ns
`default_nettype none

// match results of one bank plus the stored payload of each clause
interface cam_match_if #(
  parameter int CLAUSES_PER_BANK = 4
);

  // registered at stage 2, bit k is local clause k
  logic [CLAUSES_PER_BANK-1:0]                    match_lines;

  // payloads straight from bank storage
  cam_pkg::leaf_t     [CLAUSES_PER_BANK-1:0]      leaves;
  cam_pkg::tree_id_t  [CLAUSES_PER_BANK-1:0]      tree_ids;
  cam_pkg::class_id_t [CLAUSES_PER_BANK-1:0]      class_ids;

  modport bank (
    output match_lines,
    output leaves,
    output tree_ids,
    output class_ids
  );

  modport collector (
    input match_lines,
    input leaves,
    input tree_ids,
    input class_ids
  );

endinterface

`default_nettype wire

/* hw/cam_pkg.sv */
`default_nettype none

package cam_pkg;

  //////////////////////////////////////////////////
  // query geometry
  //////////////////////////////////////////////////

  // number of variables compared per clause
  localparam int NUM_VARS = 4;

  // bits per variable value
  localparam int VAR_WIDTH = 8;

  typedef logic [VAR_WIDTH-1:0] var_t;

  // one query or one threshold row, variable 0 in the low bits
  typedef var_t [NUM_VARS-1:0] vars_t;

  //////////////////////////////////////////////////
  // clause payload
  //////////////////////////////////////////////////

  localparam int LEAF_WIDTH = 16;

  // leaf values are signed contributions to the tree sum
  typedef logic signed [LEAF_WIDTH-1:0] leaf_t;

  localparam int TREE_ID_WIDTH = 4;

  typedef logic [TREE_ID_WIDTH-1:0] tree_id_t;

  localparam int CLASS_ID_WIDTH = 2;

  typedef logic [CLASS_ID_WIDTH-1:0] class_id_t;

  //////////////////////////////////////////////////
  // command encoding
  //////////////////////////////////////////////////

  // idle means no command on the input this cycle
  typedef enum logic [1:0] {
    MODE_INFER     = 2'd0,
    MODE_WRITE     = 2'd1,
    MODE_DONT_CARE = 2'd2,
    MODE_IDLE      = 2'd3
  } mode_t;

endpackage

`default_nettype wire

/* hw/clause_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module clause_bank #(
  parameter int CLAUSES_PER_BANK = 4,
  parameter int BANK_INDEX       = 0,
  parameter int NUM_CLAUSES      = 16
) (
  input  logic        clk,
  input  logic        rst_3,

  cam_cmd_if.bank     cmd,
  cam_match_if.bank   match
);

  localparam int CLAUSE_BITS = $clog2(NUM_CLAUSES);
  localparam int BASE        = BANK_INDEX * CLAUSES_PER_BANK;

  // threshold rows and payloads, no reset
  cam_pkg::vars_t       lower_rows  [CLAUSES_PER_BANK];
  cam_pkg::vars_t       higher_rows [CLAUSES_PER_BANK];
  cam_pkg::leaf_t       leaf_mem    [CLAUSES_PER_BANK];
  cam_pkg::tree_id_t    tree_mem    [CLAUSES_PER_BANK];
  cam_pkg::class_id_t   class_mem   [CLAUSES_PER_BANK];

  logic [CLAUSES_PER_BANK-1:0]  enabled;
  logic [CLAUSES_PER_BANK-1:0]  hit;

  //////////////////////////////////////////////////
  // writes at stage 1
  //////////////////////////////////////////////////

  // lower write carries the ids, higher write carries the leaf
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < CLAUSES_PER_BANK; k++)
    begin
      if (cmd.advance && cmd.cmd_write && (cmd.cmd_clause == CLAUSE_BITS'(BASE + k)))
      begin
        if (!cmd.cmd_tkind)
        begin
          lower_rows[k] <= cmd.cmd_vars;
          tree_mem[k]   <= cmd.cmd_tree_id;
          class_mem[k]  <= cmd.cmd_class_id;
        end
        else
        begin
          higher_rows[k] <= cmd.cmd_vars;
          leaf_mem[k]    <= cmd.cmd_leaf;
        end
      end
    end
  end

  // a clause only becomes live with its higher write
  always_ff @(posedge clk)
  begin
    if (rst_3)
    begin
      enabled <= '0;
    end
    else
    begin
      for (int k = 0; k < CLAUSES_PER_BANK; k++)
      begin
        if (cmd.advance && cmd.cmd_write && cmd.cmd_tkind &&
            (cmd.cmd_clause == CLAUSE_BITS'(BASE + k)))
        begin
          enabled[k] <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // range compare
  //////////////////////////////////////////////////

  always_comb
  begin
    logic [cam_pkg::NUM_VARS-1:0] in_range;
    for (int k = 0; k < CLAUSES_PER_BANK; k++)
    begin
      for (int j = 0; j < cam_pkg::NUM_VARS; j++)
      begin
        // half-open interval, lower included and higher excluded
        in_range[j] = (cmd.cmd_vars[j] >= lower_rows[k][j]) &&
                      (cmd.cmd_vars[j] <  higher_rows[k][j]);
      end
      hit[k] = &(in_range | cmd.dont_care) && enabled[k];
    end
  end

  // stage 2, lines stay zero for anything but a query
  always_ff @(posedge clk)
  begin
    if (rst_3)
    begin
      match.match_lines <= '0;
    end
    else if (cmd.advance)
    begin
      match.match_lines <= cmd.cmd_infer ? hit : '0;
    end
  end

  always_comb
  begin
    for (int k = 0; k < CLAUSES_PER_BANK; k++)
    begin
      match.leaves[k]    = leaf_mem[k];
      match.tree_ids[k]  = tree_mem[k];
      match.class_ids[k] = class_mem[k];
    end
  end

  // match lines registered earlier must still point at live clauses
  a_match_enabled: assert property (
    @(posedge clk) disable iff (rst_3)
    (match.match_lines & ~enabled) == '0
  );

endmodule

`default_nettype wire

/* hw/match_collector.sv */
`timescale 1ns/1ns
`default_nettype none

module match_collector #(
  parameter  int NUM_CLAUSES       = 16,
  parameter  int NUM_BANKS         = 4,
  parameter  int BRANCHES_PER_SLOT = 2,
  localparam int NUM_SLOTS         = NUM_CLAUSES / BRANCHES_PER_SLOT
) (
  input  logic                                    clk,
  input  logic                                    rst_3,

  cam_cmd_if.collector                            cmd,
  cam_match_if.collector                          banks [NUM_BANKS],

  input  logic                                    i_out_ready,
  output logic                                    o_valid,
  output cam_pkg::leaf_t     [NUM_SLOTS-1:0]      o_leaves,
  output cam_pkg::tree_id_t  [NUM_SLOTS-1:0]      o_tree_ids,
  output cam_pkg::class_id_t [NUM_SLOTS-1:0]      o_class_ids
);

  localparam int CLAUSES_PER_BANK = NUM_CLAUSES / NUM_BANKS;

  logic                   s2_valid;

  // all banks laid out by global clause index
  logic [NUM_CLAUSES-1:0] all_lines;
  cam_pkg::leaf_t         all_leaves  [NUM_CLAUSES];
  cam_pkg::tree_id_t      all_trees   [NUM_CLAUSES];
  cam_pkg::class_id_t     all_classes [NUM_CLAUSES];

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_gather
    for (genvar k = 0; k < CLAUSES_PER_BANK; k++)
    begin : g_clause
      assign all_lines[b*CLAUSES_PER_BANK + k]   = banks[b].match_lines[k];
      assign all_leaves[b*CLAUSES_PER_BANK + k]  = banks[b].leaves[k];
      assign all_trees[b*CLAUSES_PER_BANK + k]   = banks[b].tree_ids[k];
      assign all_classes[b*CLAUSES_PER_BANK + k] = banks[b].class_ids[k];
    end
  end

  // everything upstream freezes while an output is held
  assign cmd.advance = !o_valid || i_out_ready;

  //////////////////////////////////////////////////
  // stage 2 and 3 valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst_3)
    begin
      s2_valid <= 1'b0;
      o_valid  <= 1'b0;
    end
    else if (cmd.advance)
    begin
      s2_valid <= cmd.cmd_infer;
      o_valid  <= s2_valid;
    end
  end

  // slot fill, later clauses overwrite earlier ones in the same slot
  always_ff @(posedge clk)
  begin
    if (cmd.advance && s2_valid)
    begin
      o_leaves    <= '0;
      o_tree_ids  <= '0;
      o_class_ids <= '0;
      for (int c = 0; c < NUM_CLAUSES; c++)
      begin
        if (all_lines[c])
        begin
          o_leaves[c / BRANCHES_PER_SLOT]    <= all_leaves[c];
          o_tree_ids[c / BRANCHES_PER_SLOT]  <= all_trees[c];
          o_class_ids[c / BRANCHES_PER_SLOT] <= all_classes[c];
        end
      end
    end
  end

  // a result that is not taken must wait unchanged
  a_hold_output: assert property (
    @(posedge clk) disable iff (rst_3)
    (o_valid && !i_out_ready) |=>
      (o_valid && $stable(o_leaves) && $stable(o_tree_ids) && $stable(o_class_ids))
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the cam_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cam_core \
  -f filelist.f \
  -Mdir obj_dir \
  -o tb_cam_core

# a failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/tb_cam_core

/* sim/cam_model.svh */
`ifndef CAM_MODEL_SVH
`define CAM_MODEL_SVH

// slot contents of one inference result
typedef cam_pkg::leaf_t     [NUM_SLOTS-1:0] slot_leaves_t;
typedef cam_pkg::tree_id_t  [NUM_SLOTS-1:0] slot_trees_t;
typedef cam_pkg::class_id_t [NUM_SLOTS-1:0] slot_classes_t;

// clause table as seen from the command stream
cam_pkg::vars_t               m_lower   [NUM_CLAUSES];
cam_pkg::vars_t               m_higher  [NUM_CLAUSES];
cam_pkg::leaf_t               m_leaf    [NUM_CLAUSES];
cam_pkg::tree_id_t            m_tree    [NUM_CLAUSES];
cam_pkg::class_id_t           m_class   [NUM_CLAUSES];
logic [NUM_CLAUSES-1:0]       m_enabled;
logic [NUM_CLAUSES-1:0]       m_lower_set;
logic [cam_pkg::NUM_VARS-1:0] m_mask;

// expected results, oldest first
slot_leaves_t                 exp_leaves  [$];
slot_trees_t                  exp_trees   [$];
slot_classes_t                exp_classes [$];

function automatic void model_reset();
  m_enabled   = '0;
  m_lower_set = '0;
  m_mask      = '0;
endfunction

// every variable inside [lower, higher) or marked don't-care
function automatic bit clause_hits(input int c, input cam_pkg::vars_t q);
  bit ok;
  if (!m_enabled[c])
    return 1'b0;
  ok = 1'b1;
  for (int j = 0; j < cam_pkg::NUM_VARS; j++)
  begin
    if (!m_mask[j] && (q[j] < m_lower[c][j] || q[j] >= m_higher[c][j]))
      ok = 1'b0;
  end
  return ok;
endfunction

function automatic void model_infer(input cam_pkg::vars_t q);
  slot_leaves_t  lv;
  slot_trees_t   tv;
  slot_classes_t cv;
  int            s;
  lv = '0;
  tv = '0;
  cv = '0;
  // ascending walk, so the higher clause in a slot is written last
  for (int c = 0; c < NUM_CLAUSES; c++)
  begin
    if (clause_hits(c, q))
    begin
      s     = c / BRANCHES_PER_SLOT;
      lv[s] = m_leaf[c];
      tv[s] = m_tree[c];
      cv[s] = m_class[c];
    end
  end
  exp_leaves.push_back(lv);
  exp_trees.push_back(tv);
  exp_classes.push_back(cv);
endfunction

// one call per accepted command, in acceptance order
function automatic void model_accept();
  case (i_mode)
    cam_pkg::MODE_WRITE:
    begin
      if (!i_threshold_kind)
      begin
        m_lower[i_clause]     = i_vars;
        m_tree[i_clause]      = i_tree_id;
        m_class[i_clause]     = i_class_id;
        m_lower_set[i_clause] = 1'b1;
      end
      else
      begin
        m_higher[i_clause]  = i_vars;
        m_leaf[i_clause]    = i_leaf;
        m_enabled[i_clause] = 1'b1;
      end
    end
    cam_pkg::MODE_DONT_CARE: m_mask[i_variable] = 1'b1;
    cam_pkg::MODE_INFER:     model_infer(i_vars);
    default: ;
  endcase
endfunction

`endif

/* sim/tb_cam_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cam_core;

  localparam int NUM_CLAUSES       = 16;
  localparam int BRANCHES_PER_SLOT = 2;
  localparam int NUM_SLOTS         = NUM_CLAUSES / BRANCHES_PER_SLOT;
  localparam int CLAUSE_BITS       = $clog2(NUM_CLAUSES);
  localparam int VAR_SEL_BITS      = $clog2(cam_pkg::NUM_VARS);
  localparam int NUM_CMDS          = 400;
  localparam int CYCLE_LIMIT       = NUM_CMDS * 8 + 200;

  logic                              clk;
  logic                              rst_3;
  cam_pkg::mode_t                    i_mode;
  logic [CLAUSE_BITS-1:0]            i_clause;
  logic [VAR_SEL_BITS-1:0]           i_variable;
  logic                              i_threshold_kind;
  cam_pkg::vars_t                    i_vars;
  cam_pkg::leaf_t                    i_leaf;
  cam_pkg::tree_id_t                 i_tree_id;
  cam_pkg::class_id_t                i_class_id;
  logic                              o_ready;
  logic                              i_out_ready;
  logic                              o_valid;
  cam_pkg::leaf_t     [NUM_SLOTS-1:0] o_leaves;
  cam_pkg::tree_id_t  [NUM_SLOTS-1:0] o_tree_ids;
  cam_pkg::class_id_t [NUM_SLOTS-1:0] o_class_ids;

  int sent;
  bit pending;
  int cycle_count;
  int drain;

  `include "cam_model.svh"

  cam_core u_cam_core (
    .clk              (clk),
    .rst_3            (rst_3),
    .i_mode           (i_mode),
    .i_clause         (i_clause),
    .i_variable       (i_variable),
    .i_threshold_kind (i_threshold_kind),
    .i_vars           (i_vars),
    .i_leaf           (i_leaf),
    .i_tree_id        (i_tree_id),
    .i_class_id       (i_class_id),
    .o_ready          (o_ready),
    .i_out_ready      (i_out_ready),
    .o_valid          (o_valid),
    .o_leaves         (o_leaves),
    .o_tree_ids       (o_tree_ids),
    .o_class_ids      (o_class_ids)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles with %0d commands sent", cycle_count, sent);
      $display("TEST FAIL");
      $fatal(1, "run did not finish in time");
    end
  end

  //////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("Error: time %0t signal %s expected %0h actual %0h",
               $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic take_output();
    slot_leaves_t  lv;
    slot_trees_t   tv;
    slot_classes_t cv;
    if (exp_leaves.size() == 0)
    begin
      $display("output handed over at time %0t with no inference outstanding", $time);
      $display("TEST FAIL");
      $fatal(1, "unexpected output");
    end
    lv = exp_leaves.pop_front();
    tv = exp_trees.pop_front();
    cv = exp_classes.pop_front();
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      check_value($sformatf("o_leaves[%0d]", s), 64'(lv[s]), 64'(o_leaves[s]));
      check_value($sformatf("o_tree_ids[%0d]", s), 64'(tv[s]), 64'(o_tree_ids[s]));
      check_value($sformatf("o_class_ids[%0d]", s), 64'(cv[s]), 64'(o_class_ids[s]));
    end
  endtask

  // sampled mid-cycle, where inputs and outputs are settled
  task automatic observe_cycle();
    check_value("o_ready", 64'(!o_valid || i_out_ready), 64'(o_ready));
    if (o_valid && i_out_ready)
      take_output();
    if (i_mode != cam_pkg::MODE_IDLE && o_ready)
    begin
      model_accept();
      sent    = sent + 1;
      pending = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // writes dominate early so that later queries find live clauses
  task automatic pick_command(input int idx);
    int roll;
    int write_pct;
    roll             = $urandom % 100;
    write_pct        = (idx < 120) ? 70 : 25;
    i_clause         = CLAUSE_BITS'($urandom % NUM_CLAUSES);
    i_variable       = VAR_SEL_BITS'($urandom % cam_pkg::NUM_VARS);
    i_leaf           = cam_pkg::leaf_t'($urandom);
    i_tree_id        = cam_pkg::tree_id_t'($urandom);
    i_class_id       = cam_pkg::class_id_t'($urandom);
    // a higher write only goes to a clause whose lower row exists
    i_threshold_kind = 1'($urandom % 2) & m_lower_set[i_clause];
    if (idx < 4)
      i_mode = cam_pkg::MODE_INFER;
    else if (roll < 2)
      i_mode = cam_pkg::MODE_DONT_CARE;
    else if (roll < 2 + write_pct)
      i_mode = cam_pkg::MODE_WRITE;
    else
      i_mode = cam_pkg::MODE_INFER;
    // narrow value ranges keep matches and boundary hits frequent
    for (int j = 0; j < cam_pkg::NUM_VARS; j++)
    begin
      if (i_mode == cam_pkg::MODE_WRITE && !i_threshold_kind)
        i_vars[j] = cam_pkg::var_t'($urandom % 8);
      else if (i_mode == cam_pkg::MODE_WRITE)
        i_vars[j] = cam_pkg::var_t'(4 + $urandom % 14);
      else
        i_vars[j] = cam_pkg::var_t'($urandom % 16);
    end
  endtask

  task automatic drive_cycle(input bit send);
    @(posedge clk);
    #1;
    i_out_ready = ($urandom % 100) < 70;
    if (!send)
      i_mode = cam_pkg::MODE_IDLE;
    else if (!pending)
    begin
      if ($urandom % 3 == 0)
        i_mode = cam_pkg::MODE_IDLE;
      else
      begin
        pick_command(sent);
        pending = 1'b1;
      end
    end
    @(negedge clk);
    observe_cycle();
  endtask

  initial
  begin
    void'($urandom(96));
    rst_3            = 1'b1;
    i_mode           = cam_pkg::MODE_IDLE;
    i_clause         = '0;
    i_variable       = '0;
    i_threshold_kind = 1'b0;
    i_vars           = '0;
    i_leaf           = '0;
    i_tree_id        = '0;
    i_class_id       = '0;
    i_out_ready      = 1'b1;
    sent             = 0;
    pending          = 1'b0;
    cycle_count      = 0;
    drain            = 0;
    model_reset();

    repeat (4) @(posedge clk);
    #1;
    rst_3 = 1'b0;
    check_value("o_valid", 64'(0), 64'(o_valid));

    while (sent < NUM_CMDS)
      drive_cycle(1'b1);

    // let the last results drain out
    while (exp_leaves.size() != 0 && drain < 60)
    begin
      drive_cycle(1'b0);
      drain = drain + 1;
    end

    if (exp_leaves.size() == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("expected outputs never arrived, %0d results still outstanding",
               exp_leaves.size());
      $display("TEST FAIL");
      $fatal(1, "missing outputs");
    end
  end

endmodule

`default_nettype wire
